//--- acc_pkg.sv
package acc_pkg;

    localparam int DATA_WIDTH     = 16;
    localparam int NUM_LANES      = 4;
    localparam int WIN_ADDR_WIDTH = 8;
    localparam int PASS_WIDTH     = 5;
    localparam int LAYER_WIDTH    = 3;
    localparam int LANE_IDX_WIDTH = 2;

    // One lane value, wraps on overflow
    typedef logic signed [DATA_WIDTH-1:0] psum_t;

    typedef logic [NUM_LANES*DATA_WIDTH-1:0] lane_vec_t;   // Lane 0 in low bits

    typedef logic [WIN_ADDR_WIDTH-1:0] win_addr_t;   // Sliding window position
    typedef logic [PASS_WIDTH-1:0]     pass_t;       // Input channel pass
    typedef logic [LAYER_WIDTH-1:0]    layer_t;
    typedef logic [LANE_IDX_WIDTH-1:0] lane_idx_t;

    // Index of the final input channel pass per layer
    function automatic pass_t last_pass_of(input layer_t layer);
        case (layer)
            3'd0: begin
                return 5'd0;
            end
            3'd1: begin
                return 5'd3;     // 64 input channels
            end
            3'd2: begin
                return 5'd7;     // 128 input channels
            end
            3'd3: begin
                return 5'd15;    // 256 input channels
            end
            default: begin
                return 5'd0;
            end
        endcase
    endfunction

endpackage

//--- psum_bank.sv
`timescale 1ns/1ps

module psum_bank
    import acc_pkg::*;
(
    input  logic      clk,
    input  win_addr_t rd_addr,
    output lane_vec_t rd_data,
    input  logic      wr_en,
    input  win_addr_t wr_addr,
    input  lane_vec_t wr_data
);

    // One word per window position, all lanes side by side
    lane_vec_t mem [0:(1 << WIN_ADDR_WIDTH) - 1];

    // Registered read, old contents on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

//--- accum_stage.sv
`timescale 1ns/1ps

module accum_stage
    import acc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      psum_valid,
    input  win_addr_t window,
    input  pass_t     pass,
    input  lane_vec_t psum_lanes,
    input  layer_t    layer,
    output win_addr_t rd_addr,
    input  lane_vec_t rd_data,
    output logic      wr_en,
    output win_addr_t wr_addr,
    output lane_vec_t wr_data,
    output logic      sum_valid,
    output win_addr_t sum_window,
    output lane_vec_t sum_lanes
);

    // Beat registered alongside its memory read
    logic      beat_valid_q;
    logic      beat_last_q;
    win_addr_t beat_window_q;
    pass_t     beat_pass_q;
    lane_vec_t beat_lanes_q;

    // Last write, still in flight for the memory read
    logic      byp_valid_q;
    win_addr_t byp_window_q;
    lane_vec_t byp_lanes_q;

    logic      use_bypass;
    lane_vec_t old_lanes;
    lane_vec_t new_sum;

    assign rd_addr = window;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid_q  <= 1'b0;
            beat_last_q   <= 1'b0;
            beat_window_q <= '0;
            beat_pass_q   <= '0;
            beat_lanes_q  <= '0;
        end else begin
            beat_valid_q <= psum_valid;
            if (psum_valid) begin
                beat_last_q   <= (pass == last_pass_of(layer));
                beat_window_q <= window;
                beat_pass_q   <= pass;
                beat_lanes_q  <= psum_lanes;
            end
        end
    end

    // Captured on the same edge as the memory write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byp_valid_q  <= 1'b0;
            byp_window_q <= '0;
            byp_lanes_q  <= '0;
        end else begin
            byp_valid_q <= beat_valid_q;
            if (beat_valid_q) begin
                byp_window_q <= beat_window_q;
                byp_lanes_q  <= new_sum;
            end
        end
    end

    assign use_bypass = byp_valid_q && (byp_window_q == beat_window_q);
    assign old_lanes  = use_bypass ? byp_lanes_q : rd_data;

    always_comb begin
        if (beat_pass_q == '0) begin
            new_sum = beat_lanes_q;   // First pass overwrites stale sums
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                new_sum[i*DATA_WIDTH +: DATA_WIDTH] =
                    beat_lanes_q[i*DATA_WIDTH +: DATA_WIDTH]
                    + old_lanes[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    // Write back on the next edge
    assign wr_en   = beat_valid_q;
    assign wr_addr = beat_window_q;
    assign wr_data = new_sum;

    assign sum_valid  = beat_valid_q && beat_last_q;   // Last pass only
    assign sum_window = beat_window_q;
    assign sum_lanes  = new_sum;

endmodule

//--- bias_relu_stage.sv
`timescale 1ns/1ps

module bias_relu_stage
    import acc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      bias_valid,
    input  lane_idx_t bias_lane,
    input  psum_t     bias_data,
    input  logic      relu_en,
    input  logic      sum_valid,
    input  win_addr_t sum_window,
    input  lane_vec_t sum_lanes,
    output logic      result_valid,
    output win_addr_t result_window,
    output lane_vec_t result_lanes
);

    psum_t     bias_q [NUM_LANES];
    lane_vec_t biased;
    lane_vec_t relu_lanes;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                bias_q[i] <= '0;
            end
        end else if (bias_valid) begin
            bias_q[bias_lane] <= bias_data;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            biased[i*DATA_WIDTH +: DATA_WIDTH] =
                sum_lanes[i*DATA_WIDTH +: DATA_WIDTH] + bias_q[i];   // Wraps
        end
    end

    // Negative lanes clamp to zero
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (relu_en && biased[i*DATA_WIDTH + DATA_WIDTH - 1]) begin
                relu_lanes[i*DATA_WIDTH +: DATA_WIDTH] = '0;
            end else begin
                relu_lanes[i*DATA_WIDTH +: DATA_WIDTH] = biased[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid  <= 1'b0;
            result_window <= '0;
            result_lanes  <= '0;
        end else begin
            result_valid <= sum_valid;   // One cycle per result
            if (sum_valid) begin
                result_window <= sum_window;
                result_lanes  <= relu_lanes;
            end
        end
    end

endmodule

//--- accumulator_buffer.sv
`timescale 1ns/1ps

module accumulator_buffer
    import acc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      psum_valid,
    input  win_addr_t window,
    input  pass_t     pass,
    input  lane_vec_t psum_lanes,
    input  layer_t    layer,
    input  logic      relu_en,
    input  logic      bias_valid,
    input  lane_idx_t bias_lane,
    input  psum_t     bias_data,
    output logic      result_valid,
    output win_addr_t result_window,
    output lane_vec_t result_lanes
);

    // Memory side
    win_addr_t rd_addr;
    lane_vec_t rd_data;
    logic      wr_en;
    win_addr_t wr_addr;
    lane_vec_t wr_data;

    // Finished sums toward bias and ReLU
    logic      sum_valid;
    win_addr_t sum_window;
    lane_vec_t sum_lanes;

    psum_bank i_psum_bank (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    accum_stage i_accum_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .psum_valid (psum_valid),
        .window     (window),
        .pass       (pass),
        .psum_lanes (psum_lanes),
        .layer      (layer),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .sum_valid  (sum_valid),
        .sum_window (sum_window),
        .sum_lanes  (sum_lanes)
    );

    bias_relu_stage i_bias_relu_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .bias_valid    (bias_valid),
        .bias_lane     (bias_lane),
        .bias_data     (bias_data),
        .relu_en       (relu_en),
        .sum_valid     (sum_valid),
        .sum_window    (sum_window),
        .sum_lanes     (sum_lanes),
        .result_valid  (result_valid),
        .result_window (result_window),
        .result_lanes  (result_lanes)
    );

endmodule

//--- accumulator_buffer_checker.sv
`timescale 1ns/1ps

module accumulator_buffer_checker
    import acc_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      psum_valid,
    input pass_t     pass,
    input layer_t    layer,
    input logic      result_valid,
    input lane_vec_t result_lanes
);

    int   fail_count = 0;   // Read by the testbench at the end
    logic last_beat;

    assign last_beat = psum_valid && (pass == last_pass_of(layer));

    // Fixed two-cycle latency, checked both ways
    a_result_after_beat: assert property (
        @(posedge clk) disable iff (!rst_n) last_beat |-> ##2 result_valid
    ) else begin
        fail_count++;
        $error("result_valid missing two cycles after a last-pass beat");
    end

    a_beat_before_result: assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |-> $past(last_beat, 2)
    ) else begin
        fail_count++;
        $error("result_valid without a last-pass beat two cycles earlier");
    end

    a_result_known: assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |-> !$isunknown(result_lanes)
    ) else begin
        fail_count++;
        $error("result_lanes has unknown bits while result_valid is high");
    end

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
    else begin
        fail_count++;
        $error("result_valid high during reset");
    end

endmodule

bind accumulator_buffer accumulator_buffer_checker i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .psum_valid   (psum_valid),
    .pass         (pass),
    .layer        (layer),
    .result_valid (result_valid),
    .result_lanes (result_lanes)
);

//--- tb_accumulator_buffer.sv
`timescale 1ns/1ps

module tb_accumulator_buffer
    import acc_pkg::*;
();

    // Window in the high bits, lanes below
    typedef logic [WIN_ADDR_WIDTH+NUM_LANES*DATA_WIDTH-1:0] result_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      psum_valid;
    win_addr_t window;
    pass_t     pass;
    lane_vec_t psum_lanes;
    layer_t    layer;
    logic      relu_en;
    logic      bias_valid;
    lane_idx_t bias_lane;
    psum_t     bias_data;
    logic      result_valid;
    win_addr_t result_window;
    lane_vec_t result_lanes;

    result_t exp_q[$];
    result_t act_q[$];
    string   test_name;
    int      error_count = 0;
    int      check_count = 0;
    int      test_count = 0;
    bit      timed_out = 1'b0;

    accumulator_buffer i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_valid    (psum_valid),
        .window        (window),
        .pass          (pass),
        .psum_lanes    (psum_lanes),
        .layer         (layer),
        .relu_en       (relu_en),
        .bias_valid    (bias_valid),
        .bias_lane     (bias_lane),
        .bias_data     (bias_data),
        .result_valid  (result_valid),
        .result_window (result_window),
        .result_lanes  (result_lanes)
    );

    always #5 clk = ~clk;

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            act_q.push_back({result_window, result_lanes});
        end
    end

    task automatic check_value(input string label, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("error %s %s: expected %0h actual %0h", test_name, label, exp_val, act_val);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            psum_valid <= 1'b0;
            bias_valid <= 1'b0;
        end
    endtask

    task automatic send_beat(input win_addr_t win, input pass_t p, input lane_vec_t lanes);
        @(posedge clk);
        psum_valid <= 1'b1;
        bias_valid <= 1'b0;
        window     <= win;
        pass       <= p;
        psum_lanes <= lanes;
    endtask

    task automatic load_bias(input lane_idx_t lane, input psum_t value);
        @(posedge clk);
        psum_valid <= 1'b0;
        bias_valid <= 1'b1;
        bias_lane  <= lane;
        bias_data  <= value;
    endtask

    task automatic apply_config(input layer_t new_layer, input logic new_relu);
        @(posedge clk);
        psum_valid <= 1'b0;
        bias_valid <= 1'b0;
        layer      <= new_layer;
        relu_en    <= new_relu;
    endtask

    task automatic collect_result(output result_t got, output bit ok);
        int cycles;
        cycles = 0;
        while (act_q.size() == 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (act_q.size() == 0) begin
            ok  = 1'b0;
            got = '0;
        end else begin
            ok  = 1'b1;
            got = act_q.pop_front();
        end
    endtask

    task automatic close_test();
        win_addr_t exp_window;
        lane_vec_t exp_lanes;
        win_addr_t got_window;
        lane_vec_t got_lanes;
        result_t   got;
        bit        ok;
        int        errors_before;
        int        results;
        errors_before = error_count;
        results = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && !timed_out) begin
            {exp_window, exp_lanes} = exp_q.pop_front();
            collect_result(got, ok);
            if (!ok) begin
                timed_out = 1'b1;
                $display("test %s: no result for window %0h within 200 cycles",
                         test_name, exp_window);
            end else begin
                {got_window, got_lanes} = got;
                check_value("window", exp_window, got_window);
                check_value("lanes", exp_lanes, got_lanes);
                results++;
            end
        end
        if (!timed_out) begin
            idle_cycles(4);   // Past the two-cycle latency
            if (act_q.size() != 0) begin
                error_count++;
                $display("test %s: %0d results arrived that were not expected",
                         test_name, act_q.size());
                act_q.delete();
            end
            $display("test %s: %0d results, %0d mismatches",
                     test_name, results, error_count - errors_before);
        end
        test_count++;
    endtask

    initial begin
        int          fd;
        int          code;
        int          want;
        int          num_a;
        int          num_b;
        string       line;
        string       name;
        win_addr_t   w;
        logic [15:0] l0;
        logic [15:0] l1;
        logic [15:0] l2;
        logic [15:0] l3;
        bit          in_test;
        in_test    = 1'b0;
        rst_n      = 1'b0;
        psum_valid = 1'b0;
        window     = '0;
        pass       = '0;
        psum_lanes = '0;
        layer      = '0;
        relu_en    = 1'b0;
        bias_valid = 1'b0;
        bias_lane  = '0;
        bias_data  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("accum_input.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open accum_input.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                code = 0;
                want = 0;
                case (line.getc(0))
                    "T": begin
                        want = 1;
                        code = $sscanf(line, "T %s", name);
                        if (in_test) begin
                            close_test();
                        end
                        test_name = name;
                        in_test = 1'b1;
                    end
                    "C": begin
                        want = 2;
                        code = $sscanf(line, "C %d %d", num_a, num_b);
                        apply_config(layer_t'(num_a), num_b[0]);
                    end
                    "B": begin
                        want = 2;
                        code = $sscanf(line, "B %d %h", num_a, l0);
                        load_bias(lane_idx_t'(num_a), l0);
                    end
                    "P": begin
                        want = 6;
                        code = $sscanf(line, "P %h %d %h %h %h %h", w, num_a, l0, l1, l2, l3);
                        send_beat(w, pass_t'(num_a), {l3, l2, l1, l0});
                    end
                    "I": begin
                        want = 1;
                        code = $sscanf(line, "I %d", num_a);
                        idle_cycles(num_a);
                    end
                    "E": begin
                        want = 5;
                        code = $sscanf(line, "E %h %h %h %h %h", w, l0, l1, l2, l3);
                        exp_q.push_back({w, l3, l2, l1, l0});
                    end
                    default: begin
                        // Comments and blank lines
                    end
                endcase
                if (code != want) begin
                    error_count++;
                    $display("record could not be read: %s", line);
                end
            end
            if (in_test && !timed_out) begin
                close_test();
            end
            $fclose(fd);
        end

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, check_count, error_count, i_dut.i_checker.fail_count);
        if (timed_out || error_count != 0 || i_dut.i_checker.fail_count != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

//--- accum_input.txt
# T name | C layer relu_en | B lane bias (hex) | I idle cycles
# P window(hex) pass(dec) lane0 lane1 lane2 lane3 (hex)
# E window lane0 lane1 lane2 lane3, expected results in arrival order (hex)
T reset_idle
I 20
T layer0_bias
C 0 0
B 0 0010
B 1 fff0
B 2 7000
B 3 0001
P 05 0 0001 0002 7fff 8000
P 06 0 1234 0000 2000 ffff
E 05 0011 fff2 efff 8001
E 06 1244 fff0 9000 0000
T layer1_interleaved
C 1 0
B 0 0100
B 1 fffe
B 2 0000
B 3 0040
P 10 0 0001 0002 0003 0004
P 11 0 ffff 0005 8000 0001
P 12 0 7fff 0000 0100 fff0
P 10 1 0010 0020 0030 0040
P 11 1 ffff 0005 8000 0001
P 12 1 0001 0000 0100 fff0
P 10 2 0100 0200 0300 0400
P 11 2 ffff 0005 8000 0001
P 12 2 0000 0000 0100 fff0
P 10 3 1000 2000 3000 4000
P 11 3 ffff 0005 8000 0001
P 12 3 0000 0001 0100 fff0
E 10 1211 2220 3333 4484
E 11 00fc 0012 0000 0044
E 12 8100 ffff 0400 0000
T bypass_same_window
C 1 0
P 20 0 0001 0001 0001 0001
P 20 1 0002 0002 0002 0002
P 20 2 0003 0003 0003 0003
P 20 3 0004 0004 0004 fffc
P 21 0 0005 0000 1000 ffff
P 21 1 0005 0001 1000 ffff
P 22 0 0abc 0abc 0abc 0abc
P 21 2 0005 0002 1000 ffff
P 21 3 0005 0003 1000 ffff
E 20 010a 0008 000a 0042
E 21 0114 0004 4000 003c
T relu_new_layer
C 1 1
B 0 fff0
B 1 0100
B 2 0000
B 3 ffff
P 21 0 0001 fff0 0002 0000
P 21 1 0001 fff0 0002 0000
P 21 2 0001 fff0 0002 0000
P 21 3 0001 fff0 0002 0000
E 21 0000 00c0 0008 0000

//--- build.f
acc_pkg.sv
psum_bank.sv
accum_stage.sv
bias_relu_stage.sv
accumulator_buffer.sv
accumulator_buffer_checker.sv
tb_accumulator_buffer.sv
